/* hdl/servant_macros.svh */
`ifndef SERVANT_MACROS_SVH
`define SERVANT_MACROS_SVH

// RAM size in bytes, one word holds four of them
`define SERVANT_MEMSIZE 1024

// Top address bits that pick the data-bus slave
`define SERVANT_SEL_HI 31
`define SERVANT_SEL_LO 30

`endif

/* hdl/servant_pkg.sv */
`default_nettype none

package servant_pkg;

   typedef logic [31:0] wb_adr_t;
   typedef logic [31:0] wb_dat_t;
   typedef logic [3:0]  wb_sel_t;

   // Both 10 and 11 in the top address bits land on the timer
   typedef enum logic [1:0] {
      SLV_MEM   = 2'b00,
      SLV_GPIO  = 2'b01,
      SLV_TIMER = 2'b10
   } slave_e;

endpackage

`default_nettype wire

/* hdl/servant_wb_if.sv */
`default_nettype none

interface servant_wb_if import servant_pkg::*; ();

   wb_adr_t adr;
   wb_dat_t dat;
   wb_sel_t sel;
   logic    we;
   logic    cyc;
   wb_dat_t rdt;
   logic    ack;

   modport master (
      output adr, dat, sel, we, cyc,
      input  rdt, ack
   );

   modport slave (
      input  adr, dat, sel, we, cyc,
      output rdt, ack
   );

endinterface

`default_nettype wire

/* hdl/servant_arbiter.sv */
`default_nettype none

module servant_arbiter import servant_pkg::*; (
   input  wire                 i_wb_clk,
   servant_wb_if.slave         dmem,
   input  wb_adr_t             i_ibus_adr,
   input  wire                 i_ibus_cyc,
   output wb_dat_t             o_ibus_rdt,
   output logic                o_ibus_ack,
   servant_wb_if.master        mem
);

   logic dbus_owner; // Which bus issued the access now being acked

   // The data bus wins whenever it is active
   assign mem.adr = dmem.cyc ? dmem.adr : i_ibus_adr;
   assign mem.dat = dmem.dat;
   assign mem.sel = dmem.cyc ? dmem.sel : 4'hf; // Fetches are always full words
   assign mem.we  = dmem.cyc & dmem.we;
   assign mem.cyc = dmem.cyc | i_ibus_cyc;

   // The RAM acks one cycle after cyc, so the requester of the previous cycle owns the ack
   always_ff @(posedge i_wb_clk) begin
      dbus_owner <= dmem.cyc;
   end

   assign dmem.rdt   = mem.rdt;
   assign o_ibus_rdt = mem.rdt;

   assign dmem.ack   = mem.ack & dbus_owner;
   assign o_ibus_ack = mem.ack & ~dbus_owner;

endmodule

`default_nettype wire

/* hdl/servant_mux.sv */
`default_nettype none

`include "servant_macros.svh"

module servant_mux import servant_pkg::*; (
   input  wire                 i_wb_clk,
   input  wire                 i_reset,
   servant_wb_if.slave         cpu,
   servant_wb_if.master        mem,
   output logic                o_gpio_dat,
   output logic                o_gpio_we,
   output logic                o_gpio_cyc,
   input  wire                 i_gpio_rdt,
   output wb_dat_t             o_timer_dat,
   output logic                o_timer_we,
   output logic                o_timer_cyc,
   input  wb_dat_t             i_timer_rdt
);

   slave_e target;
   logic   periph_ack;

   always_comb begin
      case (cpu.adr[`SERVANT_SEL_HI:`SERVANT_SEL_LO])
         2'b00:   target = SLV_MEM;
         2'b01:   target = SLV_GPIO;
         default: target = SLV_TIMER;
      endcase
   end

   assign mem.adr = cpu.adr;
   assign mem.dat = cpu.dat;
   assign mem.sel = cpu.sel;
   assign mem.we  = cpu.we;
   assign mem.cyc = cpu.cyc & (target == SLV_MEM);

   assign o_gpio_dat = cpu.dat[0];
   assign o_gpio_we  = cpu.we;
   assign o_gpio_cyc = cpu.cyc & (target == SLV_GPIO);

   assign o_timer_dat = cpu.dat;
   assign o_timer_we  = cpu.we;
   assign o_timer_cyc = cpu.cyc & (target == SLV_TIMER);

   // Peripherals answer in one cycle, the RAM brings its own ack
   always_ff @(posedge i_wb_clk) begin
      if (i_reset) begin
         periph_ack <= 1'b0;
      end else begin
         periph_ack <= cpu.cyc & (target != SLV_MEM) & ~periph_ack;
      end
   end

   assign cpu.ack = mem.ack | periph_ack;

   // Address is still held at ack time, so the decode picks the right data
   always_comb begin
      case (target)
         SLV_MEM:  cpu.rdt = mem.rdt;
         SLV_GPIO: cpu.rdt = {31'd0, i_gpio_rdt};
         default:  cpu.rdt = i_timer_rdt;
      endcase
   end

endmodule

`default_nettype wire

/* hdl/servant_ram.sv */
`default_nettype none

`include "servant_macros.svh"

module servant_ram import servant_pkg::*; (
   input  wire          i_wb_clk,
   input  wire          i_reset,
   servant_wb_if.slave  wb
);

   localparam int DEPTH = `SERVANT_MEMSIZE / 4;
   localparam int AW    = $clog2(DEPTH);

   wb_dat_t         mem [DEPTH];
   wb_dat_t         rdt_q;
   logic            ack_q;
   logic [AW-1:0]   addr;

   assign addr = wb.adr[AW+1:2]; // Word index, byte offset dropped

   always_ff @(posedge i_wb_clk) begin
      for (int b = 0; b < 4; b++) begin
         if (wb.cyc & wb.we & wb.sel[b]) begin
            mem[addr][b*8 +: 8] <= wb.dat[b*8 +: 8];
         end
      end
      rdt_q <= mem[addr];
   end

   // One ack per access, a held cyc does not retrigger while ack is up
   always_ff @(posedge i_wb_clk) begin
      if (i_reset) begin
         ack_q <= 1'b0;
      end else begin
         ack_q <= wb.cyc & ~ack_q;
      end
   end

   assign wb.rdt = rdt_q;
   assign wb.ack = ack_q;

endmodule

`default_nettype wire

/* hdl/servant_timer.sv */
`default_nettype none

module servant_timer #(
   parameter int WIDTH = 32
) (
   input  wire               i_wb_clk,
   input  wire               i_reset,
   input  wire               i_wb_cyc,
   input  wire               i_wb_we,
   input  wire [WIDTH-1:0]   i_wb_dat,
   output logic [WIDTH-1:0]  o_wb_dat,
   output logic              o_irq
);

   logic [WIDTH-1:0] mtime;
   logic [WIDTH-1:0] mtimecmp;
   logic [WIDTH:0]   diff;

   // One extra bit turns the sign of the difference into the borrow of mtime - mtimecmp
   assign diff = {1'b0, mtime} - {1'b0, mtimecmp};

   always_ff @(posedge i_wb_clk) begin
      if (i_reset) begin
         mtime    <= '0;
         mtimecmp <= '1;
         o_irq    <= 1'b0;
      end else begin
         mtime <= mtime + 1'b1;
         if (i_wb_cyc & i_wb_we) begin
            mtimecmp <= i_wb_dat;
         end
         o_irq <= ~diff[WIDTH]; // Set once mtime has reached the compare value
      end
   end

   assign o_wb_dat = mtime;

endmodule

`default_nettype wire

/* hdl/servant_gpio.sv */
`default_nettype none

module servant_gpio (
   input  wire   i_wb_clk,
   input  wire   i_reset,
   input  wire   i_wb_dat,
   input  wire   i_wb_we,
   input  wire   i_wb_cyc,
   output logic  o_wb_rdt,
   output logic  o_gpio
);

   always_ff @(posedge i_wb_clk) begin
      if (i_reset) begin
         o_gpio   <= 1'b0;
         o_wb_rdt <= 1'b0;
      end else begin
         o_wb_rdt <= o_gpio; // Ready one cycle after cyc, in time for the ack
         if (i_wb_cyc & i_wb_we) begin
            o_gpio <= i_wb_dat;
         end
      end
   end

endmodule

`default_nettype wire

/* hdl/servant.sv */
`default_nettype none

module servant import servant_pkg::*; (
   input  wire      i_wb_clk,
   input  wire      i_reset,
   input  wb_adr_t  i_ibus_adr,
   input  wire      i_ibus_cyc,
   output wb_dat_t  o_ibus_rdt,
   output logic     o_ibus_ack,
   input  wb_adr_t  i_dbus_adr,
   input  wb_dat_t  i_dbus_dat,
   input  wb_sel_t  i_dbus_sel,
   input  wire      i_dbus_we,
   input  wire      i_dbus_cyc,
   output wb_dat_t  o_dbus_rdt,
   output logic     o_dbus_ack,
   output logic     o_q,
   output logic     o_timer_irq
);

   servant_wb_if dbus_if ();
   servant_wb_if dmem_if ();
   servant_wb_if mem_if ();

   logic    gpio_dat;
   logic    gpio_we;
   logic    gpio_cyc;
   logic    gpio_rdt;

   wb_dat_t timer_dat;
   logic    timer_we;
   logic    timer_cyc;
   wb_dat_t timer_rdt;

   // The data-bus ports stand in for the master side
   assign dbus_if.adr = i_dbus_adr;
   assign dbus_if.dat = i_dbus_dat;
   assign dbus_if.sel = i_dbus_sel;
   assign dbus_if.we  = i_dbus_we;
   assign dbus_if.cyc = i_dbus_cyc;
   assign o_dbus_rdt  = dbus_if.rdt;
   assign o_dbus_ack  = dbus_if.ack;

   servant_arbiter u_arbiter (
      .i_wb_clk   (i_wb_clk),
      .dmem       (dmem_if.slave),
      .i_ibus_adr (i_ibus_adr),
      .i_ibus_cyc (i_ibus_cyc),
      .o_ibus_rdt (o_ibus_rdt),
      .o_ibus_ack (o_ibus_ack),
      .mem        (mem_if.master)
   );

   servant_mux u_mux (
      .i_wb_clk    (i_wb_clk),
      .i_reset     (i_reset),
      .cpu         (dbus_if.slave),
      .mem         (dmem_if.master),
      .o_gpio_dat  (gpio_dat),
      .o_gpio_we   (gpio_we),
      .o_gpio_cyc  (gpio_cyc),
      .i_gpio_rdt  (gpio_rdt),
      .o_timer_dat (timer_dat),
      .o_timer_we  (timer_we),
      .o_timer_cyc (timer_cyc),
      .i_timer_rdt (timer_rdt)
   );

   servant_ram u_ram (
      .i_wb_clk (i_wb_clk),
      .i_reset  (i_reset),
      .wb       (mem_if.slave)
   );

   servant_timer #(
      .WIDTH (32)
   ) u_timer (
      .i_wb_clk (i_wb_clk),
      .i_reset  (i_reset),
      .i_wb_cyc (timer_cyc),
      .i_wb_we  (timer_we),
      .i_wb_dat (timer_dat),
      .o_wb_dat (timer_rdt),
      .o_irq    (o_timer_irq)
   );

   servant_gpio u_gpio (
      .i_wb_clk (i_wb_clk),
      .i_reset  (i_reset),
      .i_wb_dat (gpio_dat),
      .i_wb_we  (gpio_we),
      .i_wb_cyc (gpio_cyc),
      .o_wb_rdt (gpio_rdt),
      .o_gpio   (o_q)
   );

endmodule

`default_nettype wire

/* verification/servant_chk.sv */
`default_nettype none

module servant_chk (
   input  wire         i_wb_clk,
   input  wire         i_reset,
   input  wire         i_ibus_cyc,
   input  wire         i_ibus_ack,
   input  wire         i_dbus_cyc,
   input  wire         i_dbus_ack,
   input  wire [31:0]  i_ibus_adr,
   input  wire [31:0]  i_dbus_adr
);
   timeunit 1ns;
   timeprecision 1ns;

   a_dbus_ack_pulse : assert property (@(posedge i_wb_clk) disable iff (i_reset)
      i_dbus_ack |=> !i_dbus_ack) else $error("dbus ack held longer than one cycle");

   a_ibus_ack_pulse : assert property (@(posedge i_wb_clk) disable iff (i_reset)
      i_ibus_ack |=> !i_ibus_ack) else $error("ibus ack held longer than one cycle");

   // Only one master may own the RAM port at a time
   a_one_master : assert property (@(posedge i_wb_clk) disable iff (i_reset)
      !(i_ibus_cyc && i_dbus_cyc)) else $error("ibus and dbus cyc high together");

   a_dbus_adr_stable : assert property (@(posedge i_wb_clk) disable iff (i_reset)
      (i_dbus_cyc && !i_dbus_ack) |=> $stable(i_dbus_adr)) else $error("dbus address moved");

   a_ibus_adr_stable : assert property (@(posedge i_wb_clk) disable iff (i_reset)
      (i_ibus_cyc && !i_ibus_ack) |=> $stable(i_ibus_adr)) else $error("ibus address moved");

endmodule

`default_nettype wire

/* verification/servant_monitor.sv */
`default_nettype none

`include "servant_macros.svh"

module servant_monitor import servant_pkg::*; (
   input  wire      i_clk,
   input  wire      i_reset,
   input  wb_adr_t  i_ibus_adr,
   input  wire      i_ibus_cyc,
   input  wb_dat_t  i_ibus_rdt,
   input  wire      i_ibus_ack,
   input  wb_adr_t  i_dbus_adr,
   input  wb_dat_t  i_dbus_dat,
   input  wb_sel_t  i_dbus_sel,
   input  wire      i_dbus_we,
   input  wire      i_dbus_cyc,
   input  wb_dat_t  i_dbus_rdt,
   input  wire      i_dbus_ack,
   input  wire      i_q,
   input  wire      i_timer_irq,
   input  wire      i_irq_chk,
   input  wire      i_irq_exp,
   output int       o_errors,
   output int       o_checks
);
   timeunit 1ns;
   timeprecision 1ns;

   wb_dat_t shadow [`SERVANT_MEMSIZE / 4]; // Mirror of what the RAM should hold
   wb_dat_t last_time;
   logic    time_seen = 1'b0;
   logic    gpio_bit  = 1'b0;
   int      dbus_wait = 0;
   int      ibus_wait = 0;
   int      errors    = 0;
   int      checks    = 0;

   assign o_errors = errors;
   assign o_checks = checks;

   function automatic int word_index(wb_adr_t adr);
      return int'((adr % `SERVANT_MEMSIZE) / 4);
   endfunction

   function automatic wb_dat_t merge_bytes(wb_dat_t old, wb_dat_t dat, wb_sel_t sel);
      wb_dat_t res;
      res = old;
      for (int b = 0; b < 4; b++) begin
         if (sel[b]) begin
            res[8*b +: 8] = dat[8*b +: 8];
         end
      end
      return res;
   endfunction

   // Expected read data for the RAM and the GPIO, the timer is only checked for growth
   function automatic wb_dat_t expect_rdt(wb_adr_t adr);
      if (adr[`SERVANT_SEL_HI:`SERVANT_SEL_LO] == 2'b01) begin
         return {31'd0, gpio_bit};
      end
      return shadow[word_index(adr)];
   endfunction

   task automatic compare(string what, wb_dat_t got, wb_dat_t exp);
      checks++;
      if (got !== exp) begin
         errors++;
         $display("Fail %0t ns: %s got %h, expected %h", $time, what, got, exp);
      end
   endtask

   always @(negedge i_clk) begin
      if (i_reset) begin
         compare("outputs in reset", {28'd0, i_dbus_ack, i_ibus_ack, i_q, i_timer_irq}, '0);
      end else begin
         if (i_dbus_ack) begin
            compare("dbus ack latency", wb_dat_t'(dbus_wait), 32'd1);
            dbus_wait = 0;
            if (i_dbus_we && i_dbus_adr[31:30] == 2'b00) begin
               shadow[word_index(i_dbus_adr)] =
                  merge_bytes(shadow[word_index(i_dbus_adr)], i_dbus_dat, i_dbus_sel);
            end else if (i_dbus_we && i_dbus_adr[31:30] == 2'b01) begin
               gpio_bit = i_dbus_dat[0];
            end else if (!i_dbus_we && i_dbus_adr[31]) begin
               checks++;
               if (time_seen && i_dbus_rdt <= last_time) begin
                  errors++;
                  $display("Fail %0t ns: mtime read %0d not above %0d", $time, i_dbus_rdt,
                     last_time);
               end
               last_time = i_dbus_rdt;
               time_seen = 1'b1;
            end else if (!i_dbus_we) begin
               compare("dbus read", i_dbus_rdt, expect_rdt(i_dbus_adr));
            end
         end else if (i_dbus_cyc) begin
            dbus_wait++;
         end
         if (i_ibus_ack) begin
            compare("ibus ack latency", wb_dat_t'(ibus_wait), 32'd1);
            compare("ibus fetch", i_ibus_rdt, shadow[word_index(i_ibus_adr)]);
            ibus_wait = 0;
         end else if (i_ibus_cyc) begin
            ibus_wait++;
         end
         compare("gpio output", {31'd0, i_q}, {31'd0, gpio_bit});
         if (i_irq_chk) begin
            compare("timer irq", {31'd0, i_timer_irq}, {31'd0, i_irq_exp});
         end
      end
   end

endmodule

`default_nettype wire

/* verification/servant_tb.sv */
`default_nettype none

module servant_tb import servant_pkg::*; ();
   timeunit 1ns;
   timeprecision 1ns;

   localparam int      N_WORDS   = 16; // Index is taken from four random bits
   localparam int      N_OPS     = 40;
   localparam int      IRQ_WIN   = 150;
   localparam int      TOTAL_OPS = 2 * N_WORDS + 3 * N_OPS + 9;
   localparam int      WATCHDOG  = 10 * TOTAL_OPS + 2 * IRQ_WIN + 20;
   localparam wb_adr_t GPIO_ADR  = 32'h4000_0000;
   localparam wb_adr_t TIMER_ADR = 32'h8000_0000;

   logic    clk = 1'b0;
   logic    reset;
   wb_adr_t ibus_adr;
   logic    ibus_cyc;
   wb_dat_t ibus_rdt;
   logic    ibus_ack;
   wb_adr_t dbus_adr;
   wb_dat_t dbus_dat;
   wb_sel_t dbus_sel;
   logic    dbus_we;
   logic    dbus_cyc;
   wb_dat_t dbus_rdt;
   logic    dbus_ack;
   logic    q;
   logic    timer_irq;
   logic    irq_chk;
   logic    irq_exp;
   int      errors;
   int      checks;
   int      seed;
   wb_adr_t adrs [N_WORDS];

   always #50 clk = ~clk;

   servant u_servant (
      .i_wb_clk (clk),        .i_reset (reset),
      .i_ibus_adr (ibus_adr), .i_ibus_cyc (ibus_cyc),
      .o_ibus_rdt (ibus_rdt), .o_ibus_ack (ibus_ack),
      .i_dbus_adr (dbus_adr), .i_dbus_dat (dbus_dat), .i_dbus_sel (dbus_sel),
      .i_dbus_we (dbus_we),   .i_dbus_cyc (dbus_cyc),
      .o_dbus_rdt (dbus_rdt), .o_dbus_ack (dbus_ack),
      .o_q (q),               .o_timer_irq (timer_irq)
   );

   servant_monitor u_monitor (
      .i_clk (clk), .i_reset (reset),
      .i_ibus_adr (ibus_adr), .i_ibus_cyc (ibus_cyc), .i_ibus_rdt (ibus_rdt),
      .i_ibus_ack (ibus_ack), .i_dbus_adr (dbus_adr), .i_dbus_dat (dbus_dat),
      .i_dbus_sel (dbus_sel), .i_dbus_we (dbus_we), .i_dbus_cyc (dbus_cyc),
      .i_dbus_rdt (dbus_rdt), .i_dbus_ack (dbus_ack), .i_q (q), .i_timer_irq (timer_irq),
      .i_irq_chk (irq_chk), .i_irq_exp (irq_exp), .o_errors (errors), .o_checks (checks)
   );

   bind servant servant_chk u_chk (
      .i_wb_clk (i_wb_clk), .i_reset (i_reset),
      .i_ibus_cyc (i_ibus_cyc), .i_ibus_ack (o_ibus_ack), .i_ibus_adr (i_ibus_adr),
      .i_dbus_cyc (i_dbus_cyc), .i_dbus_ack (o_dbus_ack), .i_dbus_adr (i_dbus_adr)
   );

   task automatic dbus_access(input wb_adr_t adr, input wb_dat_t dat, input wb_sel_t sel,
                              input logic we, output wb_dat_t rdt);
      @(posedge clk);
      dbus_adr <= adr;
      dbus_dat <= dat;
      dbus_sel <= sel;
      dbus_we  <= we;
      dbus_cyc <= 1'b1;
      do begin
         @(negedge clk);
      end while (!dbus_ack);
      rdt = dbus_rdt;
      @(posedge clk);
      dbus_cyc <= 1'b0; // Dropped in the cycle after ack
   endtask

   task automatic ibus_fetch(input wb_adr_t adr);
      @(posedge clk);
      ibus_adr <= adr;
      ibus_cyc <= 1'b1;
      do begin
         @(negedge clk);
      end while (!ibus_ack);
      @(posedge clk);
      ibus_cyc <= 1'b0;
   endtask

   initial begin
      repeat (WATCHDOG) @(posedge clk);
      $display("Timeout: the bus sequence did not finish within %0d cycles", WATCHDOG);
      $display("Test FAILED");
      $finish;
   end

   initial begin
      wb_dat_t     rdt;
      logic [31:0] rnd;
      seed     = 44480;
      reset    = 1'b1;
      ibus_adr = '0;
      ibus_cyc = 1'b0;
      dbus_adr = '0;
      dbus_dat = '0;
      dbus_sel = '0;
      dbus_we  = 1'b0;
      dbus_cyc = 1'b0;
      irq_chk  = 1'b0;
      irq_exp  = 1'b0;
      repeat (3) @(posedge clk);
      reset   <= 1'b0;
      irq_chk <= 1'b1; // No compare value written yet
      for (int i = 0; i < N_WORDS; i++) begin
         rnd = $random(seed);
         adrs[i] = {2'b00, rnd[29:2], 2'b00}; // Upper bits alias onto the RAM
         dbus_access(adrs[i], $random(seed), 4'hf, 1'b1, rdt);
      end
      for (int i = 0; i < N_OPS; i++) begin
         rnd = $random(seed);
         dbus_access(adrs[rnd[3:0]], $random(seed), rnd[7:4], 1'b1, rdt);
         dbus_access(adrs[rnd[3:0]], '0, 4'hf, 1'b0, rdt);
         dbus_access(adrs[rnd[11:8]], '0, 4'hf, 1'b0, rdt);
      end
      for (int i = 0; i < N_WORDS; i++) begin
         ibus_fetch(adrs[i]);
      end
      dbus_access(GPIO_ADR, 32'h1, 4'hf, 1'b1, rdt);
      dbus_access(GPIO_ADR, '0, 4'hf, 1'b0, rdt);
      dbus_access(GPIO_ADR, 32'hffff_fffe, 4'hf, 1'b1, rdt);
      dbus_access(GPIO_ADR, '0, 4'hf, 1'b0, rdt);
      repeat (3) dbus_access(TIMER_ADR, '0, 4'hf, 1'b0, rdt);
      dbus_access(TIMER_ADR | 32'h4000_0000, rdt + 32'd200, 4'hf, 1'b1, rdt);
      repeat (IRQ_WIN) @(posedge clk);
      irq_chk <= 1'b0;
      repeat (IRQ_WIN) @(posedge clk);
      irq_exp <= 1'b1;
      irq_chk <= 1'b1;
      repeat (4) @(posedge clk);
      irq_chk <= 1'b0;
      dbus_access(TIMER_ADR, '1, 4'hf, 1'b1, rdt);
      @(posedge clk);
      irq_exp <= 1'b0;
      irq_chk <= 1'b1;
      repeat (10) @(posedge clk);
      @(negedge clk);
      #1;
      $display("Checks done: %0d errors in %0d comparisons", errors, checks);
      if (errors == 0) begin
         $display("Test OK");
      end else begin
         $display("Test FAILED");
      end
      $finish;
   end

endmodule

`default_nettype wire

/* servant.f */
+incdir+hdl
hdl/servant_pkg.sv
hdl/servant_wb_if.sv
hdl/servant_arbiter.sv
hdl/servant_mux.sv
hdl/servant_ram.sv
hdl/servant_timer.sv
hdl/servant_gpio.sv
hdl/servant.sv
verification/servant_chk.sv
verification/servant_monitor.sv
verification/servant_tb.sv

/* run_sim.sh */
#!/usr/bin/env bash
set -eo pipefail

cd "$(dirname "$0")"

verilator --binary --timing --assert --timescale 1ns/1ns -Wno-fatal \
   --top-module servant_tb -f servant.f -Mdir obj_dir -o servant_sim

./obj_dir/servant_sim | tee sim.log

if grep -q "Test FAILED" sim.log; then
   exit 1
fi
